// File: design/scanPkg.sv
package scanPkg;

  ////////////////////////////////////////
  // ASIC geometry
  ////////////////////////////////////////

  parameter int NumChannels = 64;

  // Three discriminators per channel on the front end
  parameter int DiscriPerChannel = 3;

  ////////////////////////////////////////
  // Configuration and scan types
  ////////////////////////////////////////

  typedef logic [9:0] dacCode_t;   // Threshold DAC code
  typedef logic [5:0] chanId_t;    // Channel number

  // One bit per channel, Ctest injection enable
  typedef logic [NumChannels-1:0] ctestMask_t;

  // Discriminator mask, channel n owns bits 3n to 3n+2
  typedef logic [DiscriPerChannel*NumChannels-1:0] discriMask_t;

  typedef logic [15:0] trigCount_t;  // Triggers per DAC step

endpackage

// File: design/streamPkg.sv
package streamPkg;

  ////////////////////////////////////////
  // Output stream word
  ////////////////////////////////////////

  typedef logic [15:0] streamWord_t;

  ////////////////////////////////////////
  // Framing and tags
  ////////////////////////////////////////

  // "SC" in ASCII, opens a scan
  parameter streamWord_t HeaderWord = 16'h5343;

  // Closes a scan, sent with last set
  parameter streamWord_t TailWord = 16'hFF45;

  // Upper byte of the channel word
  parameter logic [7:0] TagChanSingle = 8'h43;  // "C", one channel
  parameter logic [7:0] TagChanAll    = 8'h63;  // "c", all channels

  // Upper nibble of the DAC word
  parameter logic [3:0] TagDac = 4'hD;

endpackage

// File: design/streamIf.sv
`timescale 1ns/1ps

// Credit-controlled word link between two blocks
// Sender starts with as many credits as the receiver has slots
interface streamIf;
  import streamPkg::*;

  logic        valid;   // One cycle per word, never stalled
  streamWord_t data;
  logic        last;    // Marks the tail word
  logic        credit;  // One cycle per freed slot

  modport sender (
    output valid,
    output data,
    output last,
    input  credit
  );

  modport receiver (
    input  valid,
    input  data,
    input  last,
    output credit
  );

endinterface

// File: design/triggerCounter.sv
`timescale 1ns/1ps

module triggerCounter #(
  parameter int WindowCycles = 32
) (
  input  logic                Clk,
  input  logic                reset_n,
  input  logic                trigger,
  input  logic                countStart,
  output logic                countDone,
  output scanPkg::trigCount_t countValue
);
  import scanPkg::*;

  localparam int WinW = $clog2(WindowCycles + 1);

  logic [1:0]      trigSync;  // Trigger is asynchronous to Clk
  logic            trigLast;
  logic            trigEdge;
  logic            windowOn;
  logic [WinW-1:0] windowCnt;
  trigCount_t      hits;

  assign trigEdge = trigSync[1] & ~trigLast;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trigSync <= '0;
      trigLast <= 1'b0;
    end else begin
      trigSync <= {trigSync[0], trigger};
      trigLast <= trigSync[1];
    end
  end

  ////////////////////////////////////////
  // Counting window
  ////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      windowOn   <= 1'b0;
      windowCnt  <= '0;
      hits       <= '0;
      countDone  <= 1'b0;
      countValue <= '0;
    end else begin
      countDone <= 1'b0;
      if (countStart) begin
        windowOn  <= 1'b1;
        windowCnt <= '0;
        hits      <= '0;
      end else if (windowOn) begin
        windowCnt <= windowCnt + 1'b1;
        if (windowCnt == WinW'(WindowCycles - 1)) begin
          // Last window cycle, edge seen here still counts
          windowOn   <= 1'b0;
          countDone  <= 1'b1;
          countValue <= hits + trigCount_t'(trigEdge);
        end else if (trigEdge) begin
          hits <= hits + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/scanController.sv
`timescale 1ns/1ps

module scanController #(
  parameter int FifoDepth    = 8,
  parameter int SettleCycles = 20
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 testStart,
  input  logic                 singleChannel,
  input  scanPkg::chanId_t     selChannel,
  input  logic                 ctestInject,
  input  scanPkg::dacCode_t    startDac,
  input  scanPkg::dacCode_t    endDac,
  input  logic                 configDone,
  input  logic                 countDone,
  input  scanPkg::trigCount_t  countValue,
  input  logic                 transmitDone,
  output scanPkg::ctestMask_t  ctestMask,
  output scanPkg::discriMask_t discriMask,
  output scanPkg::dacCode_t    dacOut,
  output logic                 configLoad,
  output logic                 forceRaz,
  output logic                 countStart,
  output logic                 testDone,
  streamIf.sender              stream
);
  import scanPkg::*;
  import streamPkg::*;

  localparam int CreditW = $clog2(FifoDepth + 1);
  localparam int SettleW = $clog2(SettleCycles + 1);

  typedef enum logic [3:0] {
    Idle, SendHeader, SendChan, SendDac, LoadConfig, WaitConfig, WaitConfigLow,
    Settle, WaitCount, SendCount, NextStep, NextChannel, SendTail, WaitCredits, Done
  } scanState_t;

  scanState_t       state;
  logic [CreditW-1:0] creditCnt;
  logic             emitState;
  logic             sendWord;
  logic [SettleW-1:0] settleCnt;
  chanId_t          chan;
  dacCode_t         dacCode;
  logic             singleMode;  // Latched at start of scan
  logic             ctestMode;

  ////////////////////////////////////////
  // Credits toward the FIFO
  ////////////////////////////////////////

  assign emitState = state inside {SendHeader, SendChan, SendDac, SendCount, SendTail};
  assign sendWord  = emitState && (creditCnt != '0);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      creditCnt    <= CreditW'(FifoDepth);
      stream.valid <= 1'b0;
    end else begin
      creditCnt    <= creditCnt + CreditW'(stream.credit) - CreditW'(sendWord);
      stream.valid <= sendWord;
    end
  end

  ////////////////////////////////////////
  // Sweep FSM
  ////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= Idle;
      ctestMask   <= '0;
      discriMask  <= '1;          // Everything masked
      dacOut      <= '0;
      configLoad  <= 1'b0;
      forceRaz    <= 1'b0;
      countStart  <= 1'b0;
      testDone    <= 1'b0;
      settleCnt   <= '0;
      chan        <= '0;
      dacCode     <= '0;
      singleMode  <= 1'b0;
      ctestMode   <= 1'b0;
      stream.data <= '0;
      stream.last <= 1'b0;
    end else begin
      configLoad  <= 1'b0;  // Pulses
      countStart  <= 1'b0;
      stream.last <= 1'b0;
      case (state)
        Idle: begin
          ctestMask  <= '0;
          discriMask <= '1;
          testDone   <= 1'b0;
          if (testStart) begin
            singleMode <= singleChannel;
            ctestMode  <= ctestInject;
            chan       <= singleChannel ? selChannel : '0;
            dacCode    <= startDac;
            state      <= SendHeader;
          end
        end
        SendHeader: if (sendWord) begin
          stream.data <= HeaderWord;
          state       <= SendChan;
        end
        SendChan: if (sendWord) begin
          stream.data <= {singleMode ? TagChanSingle : TagChanAll, 2'b00, chan};
          ctestMask   <= ctestMode ? (ctestMask_t'(1) << chan) : '0;
          discriMask  <= discriMask_t'(3'b111) << (8'(chan) * 8'd3);
          state       <= SendDac;
        end
        SendDac: if (sendWord) begin
          stream.data <= {TagDac, 2'b00, dacCode};
          dacOut      <= {<<{dacCode}};  // ASIC shifts the LSB in first
          state       <= LoadConfig;
        end
        LoadConfig: begin
          configLoad <= 1'b1;
          forceRaz   <= 1'b1;
          state      <= WaitConfig;
        end
        WaitConfig: if (configDone) state <= WaitConfigLow;
        WaitConfigLow: if (!configDone) begin
          settleCnt <= '0;
          state     <= Settle;
        end
        Settle: begin
          settleCnt <= settleCnt + 1'b1;
          if (settleCnt == SettleW'(SettleCycles - 1)) begin
            forceRaz   <= 1'b0;
            countStart <= 1'b1;
            state      <= WaitCount;
          end
        end
        WaitCount: if (countDone) state <= SendCount;
        SendCount: if (sendWord) begin
          stream.data <= countValue;  // Held by the counter until next window
          state       <= NextStep;
        end
        NextStep: begin
          if (dacCode == endDac) begin
            dacCode <= startDac;
            state   <= NextChannel;
          end else begin
            dacCode <= dacCode + 1'b1;
            state   <= SendDac;
          end
        end
        NextChannel: begin
          if (singleMode || chan == chanId_t'(NumChannels - 1)) begin
            state <= SendTail;
          end else begin
            chan  <= chan + 1'b1;
            state <= SendChan;
          end
        end
        SendTail: if (sendWord) begin
          stream.data <= TailWord;
          stream.last <= 1'b1;
          state       <= WaitCredits;
        end
        // FIFO drained once every credit is back
        WaitCredits: if (creditCnt == CreditW'(FifoDepth)) begin
          testDone <= 1'b1;
          state    <= Done;
        end
        Done: if (transmitDone) begin
          testDone <= 1'b0;
          state    <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

// File: design/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
  parameter int FifoDepth = 8
) (
  input logic       Clk,
  input logic       reset_n,
  streamIf.receiver inPort,
  streamIf.sender   outPort
);
  import streamPkg::*;

  localparam int AddrW = $clog2(FifoDepth);
  localparam int FillW = $clog2(FifoDepth + 1);

  // Slots in the packer queue
  localparam logic [1:0] PackerCredits = 2'd2;

  streamWord_t      memData [FifoDepth];
  logic             memLast [FifoDepth];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [FillW-1:0] fill;         // Stored words
  logic [1:0]       downCredits;
  logic             popWord;

  assign popWord = (fill != '0) && (downCredits != '0);

  always_ff @(posedge Clk) begin
    if (inPort.valid) begin
      memData[wrPtr] <= inPort.data;
      memLast[wrPtr] <= inPort.last;
    end
  end

  ////////////////////////////////////////
  // Pointers and credits
  ////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr         <= '0;
      rdPtr         <= '0;
      fill          <= '0;
      downCredits   <= PackerCredits;
      inPort.credit <= 1'b0;
      outPort.valid <= 1'b0;
    end else begin
      if (inPort.valid) wrPtr <= (wrPtr == AddrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (popWord) rdPtr <= (rdPtr == AddrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      fill          <= fill + FillW'(inPort.valid) - FillW'(popWord);
      downCredits   <= downCredits + 2'(outPort.credit) - 2'(popWord);
      inPort.credit <= popWord;  // Slot freed by this pop
      outPort.valid <= popWord;
    end
  end

  // Word toward the packer
  always_ff @(posedge Clk) begin
    if (popWord) begin
      outPort.data <= memData[rdPtr];
      outPort.last <= memLast[rdPtr];
    end
  end

endmodule

// File: design/usbPacker.sv
`timescale 1ns/1ps

module usbPacker (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  outReady,
  streamIf.receiver             inPort,
  output streamPkg::streamWord_t outData,
  output logic                  outValid,
  output logic                  outLast
);
  import streamPkg::*;

  streamWord_t holdData [2];
  logic        holdLast [2];
  logic        wrSel;
  logic        rdSel;
  logic [1:0]  holdCnt;
  logic        accept;

  // Oldest entry stays on the port until taken
  assign outValid = holdCnt != 2'd0;
  assign outData  = holdData[rdSel];
  assign outLast  = outValid & holdLast[rdSel];
  assign accept   = outValid && outReady;

  always_ff @(posedge Clk) begin
    if (inPort.valid) begin
      holdData[wrSel] <= inPort.data;
      holdLast[wrSel] <= inPort.last;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrSel         <= 1'b0;
      rdSel         <= 1'b0;
      holdCnt       <= 2'd0;
      inPort.credit <= 1'b0;
    end else begin
      if (inPort.valid) wrSel <= ~wrSel;
      if (accept) rdSel <= ~rdSel;
      holdCnt       <= holdCnt + 2'(inPort.valid) - 2'(accept);
      inPort.credit <= accept;  // Entry freed
    end
  end

endmodule

// File: design/scurveTop.sv
`timescale 1ns/1ps

module scurveTop #(
  parameter int FifoDepth    = 8,
  parameter int WindowCycles = 32,
  parameter int SettleCycles = 20
) (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   testStart,
  input  logic                   singleChannel,
  input  scanPkg::chanId_t       selChannel,
  input  logic                   ctestInject,
  input  scanPkg::dacCode_t      startDac,
  input  scanPkg::dacCode_t      endDac,
  input  logic                   configDone,
  input  logic                   trigger,
  input  logic                   outReady,
  input  logic                   transmitDone,
  output scanPkg::ctestMask_t    ctestMask,
  output scanPkg::discriMask_t   discriMask,
  output scanPkg::dacCode_t      dacOut,
  output logic                   configLoad,
  output logic                   forceRaz,
  output streamPkg::streamWord_t outData,
  output logic                   outValid,
  output logic                   outLast,
  output logic                   testDone
);
  import scanPkg::*;

  logic       countStart;
  logic       countDone;
  trigCount_t countValue;

  streamIf ctrlToFifo ();
  streamIf fifoToPacker ();

  ////////////////////////////////////////
  // Producer and its counter
  ////////////////////////////////////////

  scanController #(
    .FifoDepth   (FifoDepth),
    .SettleCycles(SettleCycles)
  ) uScanController (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .testStart    (testStart),
    .singleChannel(singleChannel),
    .selChannel   (selChannel),
    .ctestInject  (ctestInject),
    .startDac     (startDac),
    .endDac       (endDac),
    .configDone   (configDone),
    .countDone    (countDone),
    .countValue   (countValue),
    .transmitDone (transmitDone),
    .ctestMask    (ctestMask),
    .discriMask   (discriMask),
    .dacOut       (dacOut),
    .configLoad   (configLoad),
    .forceRaz     (forceRaz),
    .countStart   (countStart),
    .testDone     (testDone),
    .stream       (ctrlToFifo.sender)
  );

  triggerCounter #(
    .WindowCycles(WindowCycles)
  ) uTriggerCounter (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .trigger   (trigger),
    .countStart(countStart),
    .countDone (countDone),
    .countValue(countValue)
  );

  ////////////////////////////////////////
  // Buffer and consumer
  ////////////////////////////////////////

  creditFifo #(
    .FifoDepth(FifoDepth)
  ) uCreditFifo (
    .Clk    (Clk),
    .reset_n(reset_n),
    .inPort (ctrlToFifo.receiver),
    .outPort(fifoToPacker.sender)
  );

  usbPacker uUsbPacker (
    .Clk     (Clk),
    .reset_n (reset_n),
    .outReady(outReady),
    .inPort  (fifoToPacker.receiver),
    .outData (outData),
    .outValid(outValid),
    .outLast (outLast)
  );

endmodule

// File: verif/streamFlow_checker.sv
`timescale 1ns/1ps

module streamFlow_checker #(
  parameter int FifoDepth = 8
) (
  input logic                           Clk,
  input logic                           reset_n,
  input logic                           inValid,
  input logic                           inCredit,
  input logic                           outValid,
  input logic                           outCredit,
  input logic [$clog2(FifoDepth+1)-1:0] fill
);

  localparam int CreditW = $clog2(FifoDepth + 1);

  // Mirror of the credits the controller holds, one cycle late
  logic [CreditW-1:0] senderCredits;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      senderCredits <= CreditW'(FifoDepth);
    end else begin
      senderCredits <= senderCredits + CreditW'(inCredit) - CreditW'(inValid);
    end
  end

  ////////////////////////////////////////
  // Credit and occupancy rules
  ////////////////////////////////////////

  wordNeedsCredit: assert property (@(posedge Clk) disable iff (!reset_n)
    inValid |-> senderCredits != '0)
    else $error("word received while the sender held no credit");

  creditsBounded: assert property (@(posedge Clk) disable iff (!reset_n)
    senderCredits <= CreditW'(FifoDepth))
    else $error("sender credits above FIFO depth");

  fillBounded: assert property (@(posedge Clk) disable iff (!reset_n)
    fill <= CreditW'(FifoDepth))
    else $error("FIFO holds more words than its depth");

  linksKnown: assert property (@(posedge Clk) disable iff (!reset_n)
    !$isunknown({inValid, inCredit, outValid, outCredit}))
    else $error("valid or credit unknown on a FIFO link");

endmodule

bind creditFifo streamFlow_checker #(
  .FifoDepth(FifoDepth)
) uStreamFlowChecker (
  .Clk      (Clk),
  .reset_n  (reset_n),
  .inValid  (inPort.valid),
  .inCredit (inPort.credit),
  .outValid (outPort.valid),
  .outCredit(outPort.credit),
  .fill     (fill)
);

// File: verif/scurveTb.sv
`timescale 1ns/1ps

module scurveTb;
  import scanPkg::*;
  import streamPkg::*;

  logic        Clk;
  logic        reset_n;
  logic        testStart;
  logic        singleChannel;
  chanId_t     selChannel;
  logic        ctestInject;
  dacCode_t    startDac;
  dacCode_t    endDac;
  logic        configDone;
  logic        trigger;
  logic        outReady;
  logic        transmitDone;
  ctestMask_t  ctestMask;
  discriMask_t discriMask;
  dacCode_t    dacOut;
  logic        configLoad;
  logic        forceRaz;
  streamWord_t outData;
  logic        outValid;
  logic        outLast;
  logic        testDone;

  int          errCount;
  integer      seed;
  logic        randomReady;
  int          stepNo;       // Config loads since scan start
  int          trigPulses;
  logic        razLast;
  streamWord_t gotQ [$];
  logic        lastQ [$];
  streamWord_t expQ [$];
  streamWord_t savedQ [$];

  scurveTop scurveTop_i (.*);

  initial Clk = 1'b0;
  always #20 Clk = ~Clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkWord(input streamWord_t got, input streamWord_t exp, input string what);
    if (got !== exp) begin
      errCount++;
      $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkDac(input dacCode_t got, input dacCode_t exp, input string what);
    if (got !== exp) begin
      errCount++;
      $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCtest(input ctestMask_t got, input ctestMask_t exp, input string what);
    if (got !== exp) begin
      errCount++;
      $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkDiscri(input discriMask_t got, input discriMask_t exp, input string what);
    if (got !== exp) begin
      errCount++;
      $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errCount++;
      $display("error @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic failTimeout(input string msg);
    $display("Timeout: %s", msg);
    $display("Errors: %0d, run aborted", errCount + 1);
    $display("Test failures found");
    $finish;
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic dacCode_t reverseBits(input dacCode_t code);
    dacCode_t r;
    for (int i = 0; i < $bits(dacCode_t); i++) r[i] = code[$bits(dacCode_t)-1-i];
    return r;
  endfunction

  function automatic int stepsPerChannel();
    return int'(endDac) - int'(startDac) + 1;
  endfunction

  task automatic buildExpected();
    int firstCh;
    int lastCh;
    expQ.delete();
    expQ.push_back(HeaderWord);
    firstCh = singleChannel ? int'(selChannel) : 0;
    lastCh  = singleChannel ? int'(selChannel) : NumChannels - 1;
    for (int c = firstCh; c <= lastCh; c++) begin
      expQ.push_back({singleChannel ? TagChanSingle : TagChanAll, 2'b00, 6'(c)});
      for (int d = int'(startDac); d <= int'(endDac); d++) begin
        expQ.push_back({TagDac, 2'b00, 10'(d)});
        expQ.push_back(16'((d - int'(startDac)) % 8));  // Trigger model pulse count
      end
    end
    expQ.push_back(TailWord);
  endtask

  task automatic checkConfig(input int step);
    chanId_t     ch;
    dacCode_t    dac;
    ctestMask_t  expCtest;
    discriMask_t expDiscri;
    ch  = singleChannel ? selChannel : chanId_t'(step / stepsPerChannel());
    dac = startDac + dacCode_t'(step % stepsPerChannel());
    expCtest = '0;
    if (ctestInject) expCtest[ch] = 1'b1;
    expDiscri = '0;
    for (int i = 0; i < 3; i++) expDiscri[3*ch+i] = 1'b1;
    checkDac(dacOut, reverseBits(dac), $sformatf("dacOut at step %0d", step));
    checkCtest(ctestMask, expCtest, $sformatf("ctestMask at step %0d", step));
    checkDiscri(discriMask, expDiscri, $sformatf("discriMask at step %0d", step));
    checkBit(forceRaz, 1'b1, "forceRaz at configLoad");
  endtask

  ////////////////////////////////////////
  // ASIC, trigger and output models
  ////////////////////////////////////////

  always @(posedge Clk) begin
    if (reset_n && configLoad) begin
      checkConfig(stepNo);
      stepNo++;
      repeat (2) @(posedge Clk);
      #1 configDone = 1'b1;
      repeat (4) @(posedge Clk);
      #1 configDone = 1'b0;
    end
  end

  always @(posedge Clk) razLast <= forceRaz;

  // forceRaz falls together with the window start
  always @(posedge Clk) begin
    if (reset_n && razLast && !forceRaz) begin
      trigPulses = ((stepNo - 1) % stepsPerChannel()) % 8;
      for (int k = 0; k < trigPulses; k++) begin
        #1 trigger = 1'b1;
        repeat (2) @(posedge Clk);
        #1 trigger = 1'b0;
        repeat (2) @(posedge Clk);
      end
    end
  end

  always @(posedge Clk) begin
    if (reset_n && outValid && outReady) begin
      gotQ.push_back(outData);
      lastQ.push_back(outLast);
    end
  end

  always @(posedge Clk) begin
    #1 outReady = randomReady ? 1'($random(seed)) : 1'b1;
  end

  ////////////////////////////////////////
  // Scan sequencing
  ////////////////////////////////////////

  task automatic waitDone(input logic level, input int limit);
    int n;
    n = 0;
    while (testDone !== level) begin
      @(posedge Clk);
      n++;
      if (n > limit) failTimeout($sformatf("testDone not %0b after %0d cycles", level, limit));
    end
  endtask

  task automatic waitTail(input int limit);
    int n;
    n = 0;
    while (lastQ.size() == 0 || lastQ[lastQ.size()-1] !== 1'b1) begin
      @(posedge Clk);
      n++;
      if (n > limit) failTimeout($sformatf("no tail word on the output after %0d cycles", limit));
    end
  endtask

  task automatic compareStream(input string name);
    if (gotQ.size() != expQ.size()) begin
      errCount++;
      $display("error @%0t: %s stream has %0d words, expected %0d",
               $time, name, gotQ.size(), expQ.size());
    end
    for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
      checkWord(gotQ[i], expQ[i], $sformatf("%s word %0d", name, i));
      checkBit(lastQ[i], i == expQ.size() - 1, $sformatf("%s outLast %0d", name, i));
    end
  endtask

  task automatic runScan(input logic single, input chanId_t ch, input logic ctest,
                         input dacCode_t firstDac, input dacCode_t lastDac, input string name);
    logic tailSeen;
    gotQ.delete();
    lastQ.delete();
    stepNo = 0;
    @(posedge Clk);
    #1;
    singleChannel = single;
    selChannel    = ch;
    ctestInject   = ctest;
    startDac      = firstDac;
    endDac        = lastDac;
    testStart     = 1'b1;
    @(posedge Clk);
    #1 testStart = 1'b0;
    buildExpected();
    waitDone(1'b1, 20000);
    // Packer can still hold the tail while outReady is low
    if (!randomReady) begin
      tailSeen = (lastQ.size() != 0) ? lastQ[lastQ.size()-1] : 1'b0;
      checkBit(tailSeen, 1'b1, {name, " tail before testDone"});
    end
    waitTail(200);
    compareStream(name);
    repeat (5) begin
      @(posedge Clk);
      checkBit(testDone, 1'b1, {name, " testDone held"});
    end
    #1 transmitDone = 1'b1;
    @(posedge Clk);
    #1 transmitDone = 1'b0;
    waitDone(1'b0, 10);
  endtask

  task automatic testResetState();
    checkBit(outValid, 1'b0, "outValid after reset");
    checkBit(configLoad, 1'b0, "configLoad after reset");
    checkBit(forceRaz, 1'b0, "forceRaz after reset");
    checkBit(testDone, 1'b0, "testDone after reset");
    checkCtest(ctestMask, '0, "ctestMask after reset");
    checkDiscri(discriMask, '1, "discriMask after reset");
  endtask

  task automatic testSingleCtest();
    runScan(1'b1, 6'd5, 1'b1, 10'd100, 10'd103, "single ctest");
    savedQ = gotQ;
  endtask

  task automatic testSingleInputPin();
    runScan(1'b1, 6'd5, 1'b0, 10'd100, 10'd103, "single pin");
  endtask

  task automatic testAllChannels();
    runScan(1'b0, 6'd0, 1'b1, 10'd512, 10'd512, "all channels");
  endtask

  task automatic testBackPressure();
    randomReady = 1'b1;
    runScan(1'b1, 6'd5, 1'b1, 10'd100, 10'd103, "back-pressure");
    randomReady = 1'b0;
    for (int i = 0; i < savedQ.size() && i < gotQ.size(); i++) begin
      checkWord(gotQ[i], savedQ[i], $sformatf("rerun word %0d", i));
    end
  endtask

  // Fresh scan after the done handshake, last channel and top code
  task automatic testRestart();
    runScan(1'b1, 6'd63, 1'b0, 10'd1023, 10'd1023, "restart");
  endtask

  initial begin
    seed          = 32'had75;
    errCount      = 0;
    randomReady   = 1'b0;
    stepNo        = 0;
    reset_n       = 1'b0;
    testStart     = 1'b0;
    singleChannel = 1'b0;
    selChannel    = '0;
    ctestInject   = 1'b0;
    startDac      = '0;
    endDac        = '0;
    configDone    = 1'b0;
    trigger       = 1'b0;
    outReady      = 1'b1;
    transmitDone  = 1'b0;
    repeat (3) @(posedge Clk);
    #1 reset_n = 1'b1;
    testResetState();
    testSingleCtest();
    testSingleInputPin();
    testAllChannels();
    testBackPressure();
    testRestart();
    repeat (4) @(posedge Clk);
    $display("Errors: %0d", errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: files.f
design/scanPkg.sv
design/streamPkg.sv
design/streamIf.sv
design/triggerCounter.sv
design/scanController.sv
design/creditFifo.sv
design/usbPacker.sv
design/scurveTop.sv
verif/streamFlow_checker.sv
verif/scurveTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module scurveTb -o scurveSim

./obj_dir/scurveSim 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
